//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_wb_b3_ram
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/wb_b3_ram.sv
// Wishbone B3 on-chip RAM
`timescale 1ns/1ps

module wb_b3_ram
  import wb_ram_pkg::*;
(
  input  logic             wb_clk_i,
  input  logic             wb_rst_i,
  input  logic [AW-1:0]    wb_adr_i,
  input  logic [DW-1:0]    wb_dat_i,
  input  logic [SEL_W-1:0] wb_sel_i,
  input  logic             wb_we_i,
  input  logic [1:0]       wb_bte_i,
  input  logic [2:0]       wb_cti_i,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  output logic             wb_ack_o,
  output logic             wb_err_o,
  output logic [DW-1:0]    wb_dat_o
);

  // Internal handshake
  logic                  ack;
  logic                  err;
  logic                  burst_active;
  logic                  adr_mismatch;
  logic [WORD_ADR_W-1:0] word_adr;
  logic [DW-1:0]         rd_data;

  //////////////////////////////////////////////////
  // Request bundle
  //////////////////////////////////////////////////

  wb_ram_bus_if bus ();

  assign bus.adr = wb_adr_i;
  assign bus.dat = wb_dat_i;
  assign bus.sel = wb_sel_i;
  assign bus.we  = wb_we_i;
  assign bus.cti = wb_cti_e'(wb_cti_i);
  assign bus.bte = wb_bte_e'(wb_bte_i);
  assign bus.cyc = wb_cyc_i;
  assign bus.stb = wb_stb_i;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  wb_burst_adr_gen u_adr_gen (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .bus            (bus.adr_gen),
    .ack_i          (ack),
    .burst_active_i (burst_active),
    .word_adr_o     (word_adr),
    .adr_mismatch_o (adr_mismatch)
  );

  wb_cycle_ctrl u_ctrl (
    .wb_clk_i       (wb_clk_i),
    .wb_rst_i       (wb_rst_i),
    .bus            (bus.ctrl),
    .adr_mismatch_i (adr_mismatch),
    .ack_o          (ack),
    .err_o          (err),
    .burst_active_o (burst_active)
  );

  wb_ram_array u_array (
    .wb_clk_i   (wb_clk_i),
    .bus        (bus.array),
    .word_adr_i (word_adr),
    .ack_i      (ack),
    .rd_data_o  (rd_data)
  );

  assign wb_ack_o = ack;
  assign wb_err_o = err;
  assign wb_dat_o = rd_data;

endmodule

//--- hdl/wb_burst_adr_gen.sv
// Burst address generator
`timescale 1ns/1ps

module wb_burst_adr_gen
  import wb_ram_pkg::*;
(
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  wb_ram_bus_if.adr_gen         bus,
  input  logic                  ack_i,
  input  logic                  burst_active_i,
  output logic [WORD_ADR_W-1:0] word_adr_o,
  output logic                  adr_mismatch_o
);

  // Registered cycle and burst type
  wb_cti_e cti_q;
  wb_bte_e bte_q;

  // Word address presented to the RAM
  logic [WORD_ADR_W-1:0] word_adr_q;
  logic [WORD_ADR_W-1:0] adr_next;

  // Incoming word address, byte offset dropped
  logic [WORD_ADR_W-1:0] bus_word_adr;

  assign bus_word_adr = bus.adr[MEM_ADR_WIDTH-1:2];

  // Burst tags sampled every cycle
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      cti_q <= CTI_CLASSIC;
      bte_q <= BTE_LINEAR;
    end else begin
      cti_q <= bus.cti;
      bte_q <= bus.bte;
    end
  end

  //////////////////////////////////////////////////
  // Next beat prediction
  //////////////////////////////////////////////////

  // Wrap modes touch only the low bits
  always_comb begin
    adr_next = word_adr_q;
    case (bte_q)
      BTE_LINEAR: adr_next = word_adr_q + 1'b1;
      BTE_WRAP4:  adr_next[1:0] = word_adr_q[1:0] + 2'd1;
      BTE_WRAP8:  adr_next[2:0] = word_adr_q[2:0] + 3'd1;
      BTE_WRAP16: adr_next[3:0] = word_adr_q[3:0] + 4'd1;
      default:    adr_next = word_adr_q;
    endcase
  end

  // Burst start loads via the bus path, burst_active is still low then
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      word_adr_q <= '0;
    end else if (burst_active_i) begin
      // Step only on acknowledged incrementing beats
      if ((cti_q == CTI_INCR) && ack_i) begin
        word_adr_q <= adr_next;
      end
    end else if (bus.cyc && bus.stb) begin
      word_adr_q <= bus_word_adr;
    end
  end

  assign word_adr_o = word_adr_q;

  // Master left the predicted address
  assign adr_mismatch_o = burst_active_i && (word_adr_q != bus_word_adr);

  // Address stays known across bursts and classic cycles
  a_word_adr_known : assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !$isunknown(word_adr_q)
  );

endmodule

//--- hdl/wb_cycle_ctrl.sv
// Wishbone cycle and acknowledge control
`timescale 1ns/1ps

module wb_cycle_ctrl
  import wb_ram_pkg::*;
(
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,
  wb_ram_bus_if.ctrl bus,
  input  logic       adr_mismatch_i,
  output logic       ack_o,
  output logic       err_o,
  output logic       burst_active_o
);

  // Registered feedback acknowledge
  logic ack_q;

  // Burst tracking
  logic burst_q;
  logic burst_start;
  logic burst_stop;

  // Error sources
  logic range_err;
  logic fault;

  // Top nibble ignored so the RAM can sit away from zero
  assign range_err = bus.cyc && bus.stb && (|bus.adr[AW-5:MEM_ADR_WIDTH]);
  assign fault     = range_err || adr_mismatch_i;

  //////////////////////////////////////////////////
  // Burst state
  //////////////////////////////////////////////////

  assign burst_start = bus.cyc && bus.stb && !burst_q &&
                       ((bus.cti == CTI_CONST) || (bus.cti == CTI_INCR));

  // Last beat acknowledged, or any error
  assign burst_stop = ((bus.cti == CTI_END) && bus.stb && burst_q && ack_o) || err_o;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      burst_q <= 1'b0;
    end else if (burst_start) begin
      burst_q <= 1'b1;
    end else if (burst_stop) begin
      burst_q <= 1'b0;
    end
  end

  assign burst_active_o = burst_q;

  //////////////////////////////////////////////////
  // Acknowledge register
  //////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else if (!bus.cyc) begin
      // Bus released
      ack_q <= 1'b0;
    end else if (range_err) begin
      ack_q <= 1'b1;
    end else begin
      case (bus.cti)
        // Toggle, one ack every other cycle
        CTI_CLASSIC:         ack_q <= bus.stb ^ ack_q;
        CTI_CONST, CTI_INCR: ack_q <= bus.stb;
        CTI_END:             ack_q <= bus.stb & ~ack_q;
        default:             ack_q <= ack_q;
      endcase
    end
  end

  // Split into ack or err, both gated by stb
  assign ack_o = ack_q && bus.stb && !fault;
  assign err_o = ack_q && bus.stb && fault;

  a_ack_err_excl : assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) !(ack_o && err_o)
  );

  a_resp_needs_stb : assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) (ack_o || err_o) |-> bus.stb
  );

endmodule

//--- hdl/wb_ram_array.sv
// Wishbone RAM word array
`timescale 1ns/1ps

module wb_ram_array
  import wb_ram_pkg::*;
(
  input  logic                  wb_clk_i,
  wb_ram_bus_if.array           bus,
  input  logic [WORD_ADR_W-1:0] word_adr_i,
  input  logic                  ack_i,
  output logic [DW-1:0]         rd_data_o
);

  // Storage, contents undefined until written
  logic [DW-1:0] mem [MEM_WORDS];

  // Merged write word
  logic [DW-1:0] wr_data;

  // Write strobe, one per acknowledged write beat
  logic ram_we;

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Combinational, valid during the ack cycle
  assign rd_data_o = mem[word_adr_i];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  // Byte lane merge, unselected lanes keep current word
  always_comb begin
    for (int i = 0; i < SEL_W; i++) begin
      wr_data[i*8 +: 8] = bus.sel[i] ? bus.dat[i*8 +: 8] : rd_data_o[i*8 +: 8];
    end
  end

  assign ram_we = ack_i && bus.we;

  // Takes effect on the ack edge
  always_ff @(posedge wb_clk_i) begin
    if (ram_we) begin
      mem[word_adr_i] <= wr_data;
    end
  end

  // Address from the generator must be settled when ctrl acks a write
  a_wr_adr_known : assert property (
    @(posedge wb_clk_i) ram_we |-> !$isunknown(word_adr_i)
  );

endmodule

//--- hdl/wb_ram_bus_if.sv
// Wishbone RAM request bundle
`timescale 1ns/1ps

interface wb_ram_bus_if
  import wb_ram_pkg::*;
();

  // Request fields, all driven by the top level
  logic [AW-1:0]    adr;
  logic [DW-1:0]    dat;
  logic [SEL_W-1:0] sel;
  logic             we;
  wb_cti_e          cti;
  wb_bte_e          bte;
  logic             cyc;
  logic             stb;

  // Burst address generator
  modport adr_gen (
    input adr, cti, bte, cyc, stb
  );

  // Acknowledge and error control
  modport ctrl (
    input adr, cti, cyc, stb
  );

  // Memory array, write side only
  modport array (
    input dat, sel, we
  );

endinterface

//--- hdl/wb_ram_pkg.sv
// Wishbone RAM shared definitions
package wb_ram_pkg;

  //////////////////////////////////////////////////
  // Bus dimensions
  //////////////////////////////////////////////////

  // Data and address width of the Wishbone port
  localparam int DW = 32;
  localparam int AW = 32;

  // One select bit per byte lane
  localparam int SEL_W = DW / 8;

  //////////////////////////////////////////////////
  // Memory dimensions
  //////////////////////////////////////////////////

  // Byte address bits decoded by the RAM, 4 KB
  localparam int MEM_ADR_WIDTH = 12;

  // Word address, byte offset dropped
  localparam int WORD_ADR_W = MEM_ADR_WIDTH - 2;

  // Word count follows from the word address width
  localparam int MEM_WORDS = 1 << WORD_ADR_W;

  //////////////////////////////////////////////////
  // Wishbone B3 cycle tags
  //////////////////////////////////////////////////

  // Cycle type identifier
  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    CTI_CONST   = 3'b001,
    CTI_INCR    = 3'b010,
    CTI_END     = 3'b111
  } wb_cti_e;

  // Burst type extension, wrap size of incrementing bursts
  typedef enum logic [1:0] {
    BTE_LINEAR = 2'b00,
    BTE_WRAP4  = 2'b01,
    BTE_WRAP8  = 2'b10,
    BTE_WRAP16 = 2'b11
  } wb_bte_e;

endpackage

//--- tb.f
hdl/wb_ram_pkg.sv
hdl/wb_ram_bus_if.sv
hdl/wb_burst_adr_gen.sv
hdl/wb_cycle_ctrl.sv
hdl/wb_ram_array.sv
hdl/wb_b3_ram.sv
verification/tb_clk_gen.sv
verification/tb_wb_b3_ram.sv

//--- verification/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #5 clk_o = ~clk_o;
    end
  end

  // Held for 8 rising edges, released just after the edge
  initial begin
    rst_o = 1'b1;
    repeat (8) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

//--- verification/tb_wb_b3_ram.sv
// Wishbone B3 RAM testbench
`timescale 1ns/1ps

module tb_wb_b3_ram
  import wb_ram_pkg::*;
();

  localparam int RESP_TIMEOUT = 20;
  localparam int RST_TIMEOUT  = 50;

  // One stimulus row where a single beat means a classic cycle
  typedef struct packed {
    logic             we;
    int               beats;
    wb_cti_e          cti;
    wb_bte_e          bte;
    logic [AW-1:0]    adr;
    logic [SEL_W-1:0] sel;
    logic             rnd;
    logic [DW-1:0]    data;
    int               err_beat;
  } stim_row_t;

  logic             clk;
  logic             rst;
  logic [AW-1:0]    wb_adr;
  logic [DW-1:0]    wb_dat;
  logic [SEL_W-1:0] wb_sel;
  logic             wb_we;
  logic [1:0]       wb_bte;
  logic [2:0]       wb_cti;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_ack;
  logic             wb_err;
  logic [DW-1:0]    wb_rdat;

  // Expected contents stay x until written
  logic [DW-1:0] model_mem [MEM_WORDS];
  integer        seed;

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  // we, beats, cti, bte, adr, sel, rnd, data, err_beat
  stim_row_t stim_tbl [17] = '{
    // Classic write and read back
    '{1'b1, 1, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0010, 4'hf, 1'b1, 32'h0, -1},
    '{1'b0, 1, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0010, 4'hf, 1'b0, 32'h0, -1},
    // Partial byte write
    '{1'b1, 1, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0010, 4'h5, 1'b0, 32'ha5c3_5a3c, -1},
    '{1'b0, 1, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0010, 4'hf, 1'b0, 32'h0, -1},
    // Linear incrementing bursts
    '{1'b1, 4, CTI_INCR, BTE_LINEAR, 32'h0000_0080, 4'hf, 1'b1, 32'h0, -1},
    '{1'b0, 4, CTI_INCR, BTE_LINEAR, 32'h0000_0080, 4'hf, 1'b0, 32'h0, -1},
    // Fill an 8 word block and read it back wrapped
    '{1'b1, 8, CTI_INCR, BTE_LINEAR, 32'h0000_0100, 4'hf, 1'b1, 32'h0, -1},
    '{1'b0, 4, CTI_INCR, BTE_WRAP4, 32'h0000_0104, 4'hf, 1'b0, 32'h0, -1},
    '{1'b0, 8, CTI_INCR, BTE_WRAP8, 32'h0000_0114, 4'hf, 1'b0, 32'h0, -1},
    // Out of range write leaves memory untouched
    '{1'b1, 1, CTI_CLASSIC, BTE_LINEAR, 32'h0010_0010, 4'hf, 1'b1, 32'h0, 0},
    '{1'b0, 1, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0010, 4'hf, 1'b0, 32'h0, -1},
    // Top nibble ignored
    '{1'b1, 1, CTI_CLASSIC, BTE_LINEAR, 32'ha000_0200, 4'hf, 1'b1, 32'h0, -1},
    '{1'b0, 1, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0200, 4'hf, 1'b0, 32'h0, -1},
    // Wrong address on beat 1 ends the burst
    '{1'b1, 3, CTI_INCR, BTE_LINEAR, 32'h0000_0300, 4'hf, 1'b1, 32'h0, 1},
    '{1'b0, 1, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0300, 4'hf, 1'b0, 32'h0, -1},
    // Last write of a constant address burst wins
    '{1'b1, 3, CTI_CONST, BTE_LINEAR, 32'h0000_0180, 4'hf, 1'b1, 32'h0, -1},
    '{1'b0, 1, CTI_CLASSIC, BTE_LINEAR, 32'h0000_0180, 4'hf, 1'b0, 32'h0, -1}
  };

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  wb_b3_ram DUT (
    .wb_clk_i (clk),
    .wb_rst_i (rst),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat),
    .wb_sel_i (wb_sel),
    .wb_we_i  (wb_we),
    .wb_bte_i (wb_bte),
    .wb_cti_i (wb_cti),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_ack_o (wb_ack),
    .wb_err_o (wb_err),
    .wb_dat_o (wb_rdat)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  // Byte lanes with sel clear keep the old value
  task automatic model_write(input logic [WORD_ADR_W-1:0] w, input logic [DW-1:0] d,
                             input logic [SEL_W-1:0] sel);
    for (int i = 0; i < SEL_W; i++) begin
      if (sel[i]) begin
        model_mem[w][i*8 +: 8] = d[i*8 +: 8];
      end
    end
  endtask

  // Wrapped bursts keep the block base of the word address
  function automatic logic [WORD_ADR_W-1:0] next_word(input logic [WORD_ADR_W-1:0] w,
                                                     input wb_bte_e bte, input wb_cti_e cti);
    logic [WORD_ADR_W-1:0] mask;
    case (bte)
      BTE_WRAP4:  mask = WORD_ADR_W'(3);
      BTE_WRAP8:  mask = WORD_ADR_W'(7);
      BTE_WRAP16: mask = WORD_ADR_W'(15);
      default:    mask = '1;
    endcase
    if (cti == CTI_CONST) begin
      return w;
    end
    return (w & ~mask) | ((w + WORD_ADR_W'(1)) & mask);
  endfunction

  // Sampled at the falling edge
  // Latency counts the cycles after the first
  task automatic wait_response(output logic got_ack, output logic got_err,
                               output int lat, output logic [DW-1:0] rdata);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!wb_ack && !wb_err && cnt < RESP_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!wb_ack && !wb_err) begin
      stop_run("No ack or err came back from the RAM within 20 cycles");
    end
    got_ack = wb_ack;
    got_err = wb_err;
    lat = cnt;
    rdata = wb_rdat;
  endtask

  //////////////////////////////////////////////////
  // Row execution
  //////////////////////////////////////////////////

  task automatic run_row(input stim_row_t row);
    logic [WORD_ADR_W-1:0] word;
    logic [WORD_ADR_W-1:0] beat_word;
    logic [DW-1:0]         wdata;
    logic [DW-1:0]         rdata;
    logic                  exp_err;
    logic                  got_ack;
    logic                  got_err;
    logic                  done;
    int                    lat;
    int                    b;
    word = row.adr[MEM_ADR_WIDTH-1:2];
    b = 0;
    done = 1'b0;
    while (!done) begin
      beat_word = word;
      // Off the predicted path on the marked burst beat
      if (b == row.err_beat && b > 0) begin
        beat_word = word ^ WORD_ADR_W'(16);
      end
      wdata = row.rnd ? $random(seed) : row.data;
      wb_adr = {row.adr[AW-1:MEM_ADR_WIDTH], beat_word, 2'b00};
      wb_dat = wdata;
      wb_sel = row.sel;
      wb_we = row.we;
      wb_bte = row.bte;
      if (row.beats == 1) begin
        wb_cti = CTI_CLASSIC;
      end else if (b == row.beats - 1) begin
        wb_cti = CTI_END;
      end else begin
        wb_cti = row.cti;
      end
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wait_response(got_ack, got_err, lat, rdata);
      exp_err = (b == row.err_beat);
      check_value("err", DW'(got_err), DW'(exp_err));
      check_value("ack", DW'(got_ack), DW'(!exp_err));
      // First beat one cycle late and later beats back to back
      check_value("ack latency", DW'(lat), (b == 0) ? DW'(1) : DW'(0));
      if (got_ack && !row.we) begin
        if ($isunknown(model_mem[beat_word])) begin
          stop_run("The testbench read a word it never wrote");
        end
        check_value($sformatf("read data at word %h", beat_word), rdata,
                    model_mem[beat_word]);
      end
      @(posedge clk);
      #1;
      if (got_ack && row.we) begin
        model_write(beat_word, wdata, row.sel);
      end
      b++;
      if (got_err || b == row.beats) begin
        done = 1'b1;
      end
      word = next_word(word, row.bte, row.cti);
    end
    // Release the bus for two idle cycles
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_cti = CTI_CLASSIC;
    repeat (2) @(posedge clk);
    #1;
  endtask

  initial begin
    int cnt;
    wb_adr = '0;
    wb_dat = '0;
    wb_sel = '0;
    wb_we = 1'b0;
    wb_bte = BTE_LINEAR;
    wb_cti = CTI_CLASSIC;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    seed = 32'hee10d221;
    cnt = 0;
    @(posedge clk);
    while (rst && cnt < RST_TIMEOUT) begin
      @(posedge clk);
      cnt++;
    end
    if (rst) begin
      stop_run("Reset was never released");
    end
    @(posedge clk);
    #1;
    for (int r = 0; r < $size(stim_tbl); r++) begin
      run_row(stim_tbl[r]);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
